// File: source/cp0Pkg.sv
// Shared CP0 types; every CP0 module imports this package with a wildcard import
`default_nettype none

package cp0Pkg;

    // Implemented register numbers
    typedef enum logic [4:0] {
        addrBadVAddr = 5'd8,
        addrCount    = 5'd9,
        addrCompare  = 5'd11,
        addrStatus   = 5'd12,
        addrCause    = 5'd13,
        addrEpc      = 5'd14,
        addrPrId     = 5'd15
    } cp0Addr_e;

    // Exception classes reported by the pipeline
    typedef enum logic [3:0] {
        excNone,
        excInterrupt,
        excAddrErrFetch,
        excAddrErrLoad,
        excAddrErrStore,
        excSyscall,
        excBreak,
        excReservedInstr,
        excCpUnusable,
        excOverflow,
        excTrap,
        excEret,
        excRefetch
    } excType_e;

    typedef enum logic [4:0] {
        codeInt  = 5'd0,
        codeAdEL = 5'd4,
        codeAdES = 5'd5,
        codeSys  = 5'd8,
        codeBp   = 5'd9,
        codeRI   = 5'd10,
        codeCpU  = 5'd11,
        codeOv   = 5'd12,
        codeTr   = 5'd13
    } excCode_e;

    typedef struct packed {
        logic        en;
        cp0Addr_e    addr;
        logic [31:0] data;
    } cp0WrReq_t;

    typedef struct packed {
        excType_e    excType;
        logic [31:0] pc;
        logic        inDelaySlot;
        logic [31:0] aluOut;    // Faulting data address
    } excInfo_t;

    typedef struct packed {
        logic [8:0] zero31To23;
        logic       bev;
        logic [5:0] zero21To16;
        logic [7:0] im;
        logic [5:0] zero7To2;
        logic       exl;
        logic       ie;
    } statusFields_t;

    typedef struct packed {
        logic        bd;
        logic        ti;
        logic [1:0]  ce;
        logic [11:0] zero27To16;
        logic [7:0]  ip;
        logic        zero7;
        logic [4:0]  excCode;
        logic [1:0]  zero1To0;
    } causeFields_t;

    // MTC0 data seen as either register layout
    typedef union packed {
        logic [31:0]   raw;
        statusFields_t status;
        causeFields_t  cause;
    } cp0WrWord_u;

    typedef struct packed {
        logic       ie;
        logic       exl;
        logic       bev;
        logic [7:0] im;
        logic [7:0] ip;
    } intrView_t;

    typedef struct packed {
        logic        exl;
        logic        bd;
        logic        ce;    // Only CE0 is ever set
        excCode_e    excCode;
        logic [31:0] epc;
        logic [31:0] badVAddr;
    } excState_t;

endpackage

`default_nettype wire

// File: source/cp0Timer.sv
// Count/Compare timer with sticky timer interrupt, instantiated by the CP0 top level
`default_nettype none

module cp0Timer import cp0Pkg::*; #(
    parameter int countDivLog2 = 1
) (
    input  logic        clk,
    input  logic        rstN,
    input  cp0WrReq_t   wrReq,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timerIrq
);

    localparam int phaseW = (countDivLog2 > 0) ? countDivLog2 : 1;
    localparam logic [phaseW-1:0] phaseLast = phaseW'((1 << countDivLog2) - 1);

    logic [phaseW-1:0] phase;
    logic              countWr;
    logic              compareWr;
    logic              match;

    assign countWr   = wrReq.en && (wrReq.addr == addrCount);
    assign compareWr = wrReq.en && (wrReq.addr == addrCompare);
    assign match     = (count == compare);

    // Writing Count restarts the prescaler
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= '0;
            count <= '0;
        end else if (countWr) begin
            phase <= '0;
            count <= wrReq.data;
        end else if (phase == phaseLast) begin
            phase <= '0;
            count <= count + 32'd1;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            compare  <= '1;
            timerIrq <= 1'b0;
        end else if (compareWr) begin
            compare  <= wrReq.data;
            timerIrq <= 1'b0;    // Acknowledge
        end else if (match) begin
            timerIrq <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/cp0StatusRegs.sv
// Status control bits and Cause pending bits, feeding the core's interrupt detector
`default_nettype none

module cp0StatusRegs import cp0Pkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  cp0WrReq_t  wrReq,
    input  logic [5:0] hwInt,
    input  logic       timerIrq,
    input  logic       exl,
    output intrView_t  intrView
);

    cp0WrWord_u wrWord;
    logic       statusWr;
    logic       causeWr;

    logic       bev;
    logic [7:0] im;
    logic       ie;
    logic [1:0] ipSw;
    logic [5:0] ipHw;

    assign wrWord.raw = wrReq.data;
    assign statusWr   = wrReq.en && (wrReq.addr == addrStatus);
    assign causeWr    = wrReq.en && (wrReq.addr == addrCause);

    // EXL is handled by the exception unit
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bev <= 1'b1;
            im  <= '0;
            ie  <= 1'b0;
        end else if (statusWr) begin
            bev <= wrWord.status.bev;
            im  <= wrWord.status.im;
            ie  <= wrWord.status.ie;
        end
    end

    // Software interrupts IP1..0
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ipSw <= '0;
        end else if (causeWr) begin
            ipSw <= wrWord.cause.ip[1:0];
        end
    end

    // Timer shares line 7 with the top hardware input
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ipHw <= '0;
        end else begin
            ipHw <= hwInt | {timerIrq, 5'b0};
        end
    end

    assign intrView.ie  = ie;
    assign intrView.exl = exl;
    assign intrView.bev = bev;
    assign intrView.im  = im;
    assign intrView.ip  = {ipHw, ipSw};

endmodule

`default_nettype wire

// File: source/cp0ExcUnit.sv
// Exception recording for EPC, EXL, BD, ExcCode, CE and BadVAddr, driven from the MEM stage
`default_nettype none

module cp0ExcUnit import cp0Pkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  cp0WrReq_t wrReq,
    input  excInfo_t  exc,
    output excState_t state
);

    cp0WrWord_u wrWord;
    logic       statusWr;
    logic       epcWr;
    logic       excTaken;
    logic       isEret;
    logic       enterExc;
    logic       codeValid;
    excCode_e   code;

    assign wrWord.raw = wrReq.data;
    assign statusWr   = wrReq.en && (wrReq.addr == addrStatus);
    assign epcWr      = wrReq.en && (wrReq.addr == addrEpc);

    assign excTaken = (exc.excType != excNone) && (exc.excType != excRefetch);
    assign isEret   = (exc.excType == excEret);
    // Nested exceptions keep the first EPC and BD
    assign enterExc = excTaken && !isEret && !state.exl;

    always_comb begin
        codeValid = 1'b1;
        code      = codeInt;
        case (exc.excType)
            excInterrupt:     code = codeInt;
            excAddrErrFetch:  code = codeAdEL;
            excAddrErrLoad:   code = codeAdEL;
            excAddrErrStore:  code = codeAdES;
            excSyscall:       code = codeSys;
            excBreak:         code = codeBp;
            excReservedInstr: code = codeRI;
            excCpUnusable:    code = codeCpU;
            excOverflow:      code = codeOv;
            excTrap:          code = codeTr;
            default:          codeValid = 1'b0;    // none, eret, refetch
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state.exl <= 1'b0;
        end else if (excTaken) begin
            state.exl <= !isEret;
        end else if (statusWr) begin
            state.exl <= wrWord.status.exl;
        end
    end

    // Delay slot restarts at the branch
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state.epc <= '0;
            state.bd  <= 1'b0;
        end else if (excTaken) begin
            if (enterExc) begin
                state.epc <= exc.inDelaySlot ? exc.pc - 32'd4 : exc.pc;
                state.bd  <= exc.inDelaySlot;
            end
        end else if (epcWr) begin
            state.epc <= wrReq.data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state.excCode <= codeInt;
            state.ce      <= 1'b0;
        end else begin
            if (codeValid) state.excCode <= code;
            if (exc.excType == excCpUnusable) state.ce <= 1'b1;    // Only CP1 use traps
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state.badVAddr <= '0;
        end else if (exc.excType == excAddrErrFetch) begin
            state.badVAddr <= exc.pc;
        end else if (exc.excType == excAddrErrLoad || exc.excType == excAddrErrStore) begin
            state.badVAddr <= exc.aluOut;
        end
    end

endmodule

`default_nettype wire

// File: source/cp0ReadPort.sv
// MFC0 read multiplexer; assembles architectural register words from the CP0 blocks
`default_nettype none

module cp0ReadPort import cp0Pkg::*; #(
    parameter logic [31:0] prIdValue = 32'h00004220
) (
    input  cp0Addr_e    rdAddr,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    input  logic        timerIrq,
    input  intrView_t   intrView,
    input  excState_t   excState,
    output logic [31:0] rdData
);

    statusFields_t statusWord;
    causeFields_t  causeWord;

    // Unused fields read as zero
    always_comb begin
        statusWord     = '0;
        statusWord.bev = intrView.bev;
        statusWord.im  = intrView.im;
        statusWord.exl = intrView.exl;
        statusWord.ie  = intrView.ie;
    end

    always_comb begin
        causeWord         = '0;
        causeWord.bd      = excState.bd;
        causeWord.ti      = timerIrq;
        causeWord.ce      = {1'b0, excState.ce};
        causeWord.ip      = intrView.ip;
        causeWord.excCode = excState.excCode;
    end

    always_comb begin
        case (rdAddr)
            addrBadVAddr: rdData = excState.badVAddr;
            addrCount:    rdData = count;
            addrCompare:  rdData = compare;
            addrStatus:   rdData = statusWord;
            addrCause:    rdData = causeWord;
            addrEpc:      rdData = excState.epc;
            addrPrId:     rdData = prIdValue;
            default:      rdData = '0;    // Unimplemented register
        endcase
    end

endmodule

`default_nettype wire

// File: source/cp0Top.sv
// CP0 register file top level; connect to the MEM stage writes, exceptions and MFC0 read
`default_nettype none

module cp0Top import cp0Pkg::*; #(
    parameter logic [31:0] prIdValue    = 32'h00004220,
    parameter int          countDivLog2 = 1
) (
    input  logic        clk,
    input  logic        rstN,
    input  cp0WrReq_t   wrReq,
    input  excInfo_t    exc,
    input  logic [5:0]  hwInt,
    input  cp0Addr_e    rdAddr,
    output logic [31:0] rdData,
    output intrView_t   intrView,
    output logic [31:0] epc
);

    logic [31:0] count;
    logic [31:0] compare;
    logic        timerIrq;
    excState_t   excState;

    cp0Timer #(
        .countDivLog2(countDivLog2)
    ) u_cp0Timer (
        .clk     (clk),
        .rstN    (rstN),
        .wrReq   (wrReq),
        .count   (count),
        .compare (compare),
        .timerIrq(timerIrq)
    );

    cp0StatusRegs u_cp0StatusRegs (
        .clk     (clk),
        .rstN    (rstN),
        .wrReq   (wrReq),
        .hwInt   (hwInt),
        .timerIrq(timerIrq),
        .exl     (excState.exl),    // EXL lives in the exception unit
        .intrView(intrView)
    );

    cp0ExcUnit u_cp0ExcUnit (
        .clk  (clk),
        .rstN (rstN),
        .wrReq(wrReq),
        .exc  (exc),
        .state(excState)
    );

    cp0ReadPort #(
        .prIdValue(prIdValue)
    ) u_cp0ReadPort (
        .rdAddr  (rdAddr),
        .count   (count),
        .compare (compare),
        .timerIrq(timerIrq),
        .intrView(intrView),
        .excState(excState),
        .rdData  (rdData)
    );

    assign epc = excState.epc;

endmodule

`default_nettype wire

// File: tb/cp0Top_properties.sv
// Concurrent checks on the CP0 top-level ports, bound into every cp0Top instance
`default_nettype none

module cp0TopProperties import cp0Pkg::*; (
    input logic      clk,
    input logic      rstN,
    input excInfo_t  exc,
    input intrView_t intrView
);

    timeunit 1ns;
    timeprecision 100ps;

    logic entersExc;
    int   failCount = 0;

    // Refetch and ERET never raise EXL
    assign entersExc = (exc.excType != excNone) && (exc.excType != excRefetch) &&
                       (exc.excType != excEret);

    excSetsExl: assert property (@(posedge clk) disable iff (!rstN)
        entersExc |=> intrView.exl)
        else begin
            $error("EXL still low one cycle after an exception");
            failCount++;
        end

    eretClearsExl: assert property (@(posedge clk) disable iff (!rstN)
        (exc.excType == excEret) |=> !intrView.exl)
        else begin
            $error("EXL still high one cycle after ERET");
            failCount++;
        end

    // Boot vectors right out of reset
    bevAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> intrView.bev)
        else begin
            $error("BEV low in the first cycle after reset release");
            failCount++;
        end

endmodule

bind cp0Top cp0TopProperties u_cp0TopProperties (
    .clk     (clk),
    .rstN    (rstN),
    .exc     (exc),
    .intrView(intrView)
);

`default_nettype wire

// File: tb/cp0Tb.sv
// Table-driven testbench for the CP0 register file; build and run it with the Makefile
`default_nettype none

module cp0Tb import cp0Pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] prIdValue    = 32'h00004220;
    localparam int          countDivLog2 = 1;

    typedef struct packed {
        logic [2:0]  test;
        cp0WrReq_t   wr;
        excInfo_t    exc;
        logic [5:0]  hwInt;
        cp0Addr_e    rdAddr;
        logic [7:0]  idle;
        logic [31:0] expRd;
        intrView_t   expIntr;
        logic [31:0] expEpc;
    } step_t;

    logic        clk = 1'b0;
    logic        rstN;
    cp0WrReq_t   wrReq;
    excInfo_t    exc;
    logic [5:0]  hwInt;
    cp0Addr_e    rdAddr;
    logic [31:0] rdData;
    intrView_t   intrView;
    logic [31:0] epc;

    step_t       steps[$];
    logic [31:0] lcgState = 32'he42d;
    int          cycleLimit = 0;
    int          cycleCount = 0;
    int          testErrors = 0;
    int          totalErrors = 0;
    int          passedTests = 0;
    int          failedTests = 0;

    // Reference model state
    logic        mBev = 1'b1;
    logic [7:0]  mIm = '0;
    logic        mIe = 1'b0;
    logic        mExl = 1'b0;
    logic [1:0]  mIpSw = '0;
    logic [5:0]  mIpHw = '0;
    logic        mTi = 1'b0;
    logic        mBd = 1'b0;
    logic [1:0]  mCe = '0;
    logic [4:0]  mExcCode = '0;
    logic [31:0] mEpc = '0;
    logic [31:0] mBadVAddr = '0;
    logic [31:0] mCountBase = '0;
    int          mTicks = 0;    // Clocks since the last Count load
    logic [31:0] mCompare = '1;
    logic [5:0]  prevHw = '0;

    cp0Top #(
        .prIdValue   (prIdValue),
        .countDivLog2(countDivLog2)
    ) u_cp0Top (
        .clk     (clk),
        .rstN    (rstN),
        .wrReq   (wrReq),
        .exc     (exc),
        .hwInt   (hwInt),
        .rdAddr  (rdAddr),
        .rdData  (rdData),
        .intrView(intrView),
        .epc     (epc)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic cp0WrReq_t writeReq(input cp0Addr_e a, input logic [31:0] d);
        return '{en: 1'b1, addr: a, data: d};
    endfunction

    function automatic cp0WrReq_t noWrite();
        return '{en: 1'b0, addr: addrStatus, data: 32'd0};
    endfunction

    function automatic excInfo_t excReport(input excType_e t, input logic [31:0] pc,
            input logic ds, input logic [31:0] alu);
        return '{excType: t, pc: pc, inDelaySlot: ds, aluOut: alu};
    endfunction

    function automatic excInfo_t noExc();
        return excReport(excNone, 32'd0, 1'b0, 32'd0);
    endfunction

    function automatic logic [31:0] modelCount();
        return mCountBase + 32'(mTicks >> countDivLog2);
    endfunction

    // One rising edge of the register file, all rules applied to the old state
    function automatic void modelEdge(input cp0WrReq_t w, input excInfo_t e,
            input logic [5:0] hw);
        logic taken;
        logic oldExl;
        logic match;
        taken  = (e.excType != excNone) && (e.excType != excRefetch);
        oldExl = mExl;
        match  = (modelCount() == mCompare);
        mIpHw  = hw | {mTi, 5'b0};
        if (w.en && w.addr == addrCompare) begin
            mCompare = w.data;
            mTi      = 1'b0;
        end else if (match) begin
            mTi = 1'b1;
        end
        if (w.en && w.addr == addrCount) begin
            mCountBase = w.data;
            mTicks     = 0;
        end else begin
            mTicks = mTicks + 1;
        end
        if (w.en && w.addr == addrStatus) begin
            mBev = w.data[22];
            mIm  = w.data[15:8];
            mIe  = w.data[0];
            if (!taken) mExl = w.data[1];
        end
        if (w.en && w.addr == addrCause) mIpSw = w.data[9:8];
        if (w.en && w.addr == addrEpc && !taken) mEpc = w.data;
        if (e.excType == excEret) begin
            mExl = 1'b0;
        end else if (taken) begin
            mExl = 1'b1;
            if (!oldExl) begin
                mEpc = e.inDelaySlot ? e.pc - 32'd4 : e.pc;
                mBd  = e.inDelaySlot;
            end
        end
        case (e.excType)
            excInterrupt:                    mExcCode = 5'd0;
            excAddrErrFetch, excAddrErrLoad: mExcCode = 5'd4;
            excAddrErrStore:                 mExcCode = 5'd5;
            excSyscall:                      mExcCode = 5'd8;
            excBreak:                        mExcCode = 5'd9;
            excReservedInstr:                mExcCode = 5'd10;
            excCpUnusable:                   mExcCode = 5'd11;
            excOverflow:                     mExcCode = 5'd12;
            excTrap:                         mExcCode = 5'd13;
            default: ;
        endcase
        if (e.excType == excCpUnusable) mCe = 2'b01;
        if (e.excType == excAddrErrFetch) mBadVAddr = e.pc;
        if (e.excType == excAddrErrLoad || e.excType == excAddrErrStore) mBadVAddr = e.aluOut;
    endfunction

    function automatic logic [31:0] modelRead(input cp0Addr_e a);
        case (a)
            addrBadVAddr: return mBadVAddr;
            addrCount:    return modelCount();
            addrCompare:  return mCompare;
            addrStatus:   return {9'd0, mBev, 6'd0, mIm, 6'd0, mExl, mIe};
            addrCause:    return {mBd, mTi, mCe, 12'd0, mIpHw, mIpSw, 1'b0, mExcCode, 2'd0};
            addrEpc:      return mEpc;
            addrPrId:     return prIdValue;
            default:      return 32'd0;
        endcase
    endfunction

    function automatic intrView_t modelIntr();
        return '{ie: mIe, exl: mExl, bev: mBev, im: mIm, ip: {mIpHw, mIpSw}};
    endfunction

    // Idle edge before the step, the step edge, then the idle edges
    function automatic void addStep(input logic [2:0] test, input cp0WrReq_t w,
            input excInfo_t e, input logic [5:0] hw, input cp0Addr_e a, input int idle);
        step_t s;
        modelEdge(noWrite(), noExc(), prevHw);
        modelEdge(w, e, hw);
        repeat (idle) modelEdge(noWrite(), noExc(), hw);
        prevHw    = hw;
        s.test    = test;
        s.wr      = w;
        s.exc     = e;
        s.hwInt   = hw;
        s.rdAddr  = a;
        s.idle    = 8'(idle);
        s.expRd   = modelRead(a);
        s.expIntr = modelIntr();
        s.expEpc  = mEpc;
        steps.push_back(s);
    endfunction

    function automatic void buildTable();
        logic [31:0] v;
        excInfo_t    eret;
        eret = excReport(excEret, 32'd0, 1'b0, 32'd0);
        addStep(3'd0, noWrite(), noExc(), 6'd0, addrStatus, 0);
        addStep(3'd0, noWrite(), noExc(), 6'd0, addrCause, 0);
        addStep(3'd0, noWrite(), noExc(), 6'd0, addrEpc, 0);
        addStep(3'd0, noWrite(), noExc(), 6'd0, addrBadVAddr, 0);
        addStep(3'd0, noWrite(), noExc(), 6'd0, addrCompare, 0);
        addStep(3'd0, noWrite(), noExc(), 6'd0, addrPrId, 0);
        addStep(3'd0, noWrite(), noExc(), 6'd0, cp0Addr_e'(5'd3), 0);
        addStep(3'd0, noWrite(), noExc(), 6'd0, cp0Addr_e'(5'd31), 0);
        addStep(3'd1, writeReq(addrStatus, nextRand()), noExc(), 6'd0, addrStatus, 0);
        addStep(3'd1, writeReq(addrStatus, 32'hffffffff), noExc(), 6'd0, addrStatus, 0);
        addStep(3'd1, writeReq(addrCause, nextRand()), noExc(), 6'd0, addrCause, 0);
        addStep(3'd1, writeReq(addrCause, 32'hffffffff), noExc(), 6'd0, addrCause, 0);
        addStep(3'd1, writeReq(addrEpc, nextRand()), noExc(), 6'd0, addrEpc, 0);
        addStep(3'd1, writeReq(addrBadVAddr, nextRand()), noExc(), 6'd0, addrBadVAddr, 0);
        addStep(3'd1, writeReq(addrPrId, nextRand()), noExc(), 6'd0, addrPrId, 0);
        addStep(3'd1, writeReq(addrStatus, 32'h00400000), noExc(), 6'd0, addrStatus, 0);
        addStep(3'd2, noWrite(), excReport(excSyscall, nextRand(), 1'b0, 32'd0), 6'd0, addrEpc, 0);
        addStep(3'd2, noWrite(), noExc(), 6'd0, addrCause, 0);
        addStep(3'd2, noWrite(), eret, 6'd0, addrStatus, 0);
        addStep(3'd2, noWrite(), excReport(excOverflow, nextRand(), 1'b1, 32'd0), 6'd0, addrEpc, 0);
        addStep(3'd2, noWrite(), noExc(), 6'd0, addrCause, 0);
        addStep(3'd2, noWrite(), excReport(excBreak, nextRand(), 1'b0, 32'd0), 6'd0, addrCause, 0);
        addStep(3'd2, noWrite(), noExc(), 6'd0, addrEpc, 0);
        addStep(3'd2, writeReq(addrEpc, nextRand()), eret, 6'd0, addrEpc, 0);    // EPC kept
        addStep(3'd2, noWrite(), noExc(), 6'd0, addrStatus, 0);
        addStep(3'd2, noWrite(), excReport(excCpUnusable, nextRand(), 1'b0, 32'd0), 6'd0,
            addrCause, 0);
        addStep(3'd2, noWrite(), eret, 6'd0, addrStatus, 0);
        v = nextRand();
        addStep(3'd2, writeReq(addrStatus, 32'h00400000), excReport(excReservedInstr, v, 1'b0,
            32'd0), 6'd0, addrStatus, 0);
        addStep(3'd2, noWrite(), noExc(), 6'd0, addrCause, 0);
        addStep(3'd2, noWrite(), eret, 6'd0, addrEpc, 0);
        addStep(3'd2, noWrite(), excReport(excInterrupt, nextRand(), 1'b0, 32'd0), 6'd0,
            addrCause, 0);
        addStep(3'd2, noWrite(), eret, 6'd0, addrStatus, 0);
        addStep(3'd2, noWrite(), excReport(excRefetch, nextRand(), 1'b0, 32'd0), 6'd0,
            addrStatus, 0);
        addStep(3'd2, noWrite(), excReport(excTrap, nextRand(), 1'b1, 32'd0), 6'd0, addrCause, 0);
        addStep(3'd2, noWrite(), noExc(), 6'd0, addrEpc, 0);
        addStep(3'd3, noWrite(), eret, 6'd0, addrStatus, 0);
        addStep(3'd3, noWrite(), excReport(excAddrErrFetch, nextRand(), 1'b0, nextRand()), 6'd0,
            addrBadVAddr, 0);
        addStep(3'd3, noWrite(), excReport(excAddrErrLoad, nextRand(), 1'b0, nextRand()), 6'd0,
            addrBadVAddr, 0);
        addStep(3'd3, noWrite(), noExc(), 6'd0, addrCause, 0);
        addStep(3'd3, noWrite(), excReport(excAddrErrStore, nextRand(), 1'b0, nextRand()), 6'd0,
            addrBadVAddr, 0);
        addStep(3'd3, noWrite(), noExc(), 6'd0, addrCause, 0);
        addStep(3'd3, noWrite(), eret, 6'd0, addrStatus, 0);
        addStep(3'd4, writeReq(addrCount, nextRand()), noExc(), 6'd0, addrCount, 0);
        addStep(3'd4, noWrite(), noExc(), 6'd0, addrCount, 5);
        addStep(3'd4, writeReq(addrCount, nextRand()), noExc(), 6'd0, addrCount, 8);
        addStep(3'd4, writeReq(addrCount, 32'h00000100), noExc(), 6'd0, addrCount, 3);
        addStep(3'd4, writeReq(addrCompare, 32'h00000108), noExc(), 6'd0, addrCause, 20);
        addStep(3'd4, noWrite(), noExc(), 6'd0, addrCount, 0);
        addStep(3'd4, writeReq(addrCompare, 32'hffffffff), noExc(), 6'd0, addrCause, 0);
        addStep(3'd4, noWrite(), noExc(), 6'd0, addrCause, 1);
        addStep(3'd4, noWrite(), noExc(), 6'd0, addrCompare, 0);
        addStep(3'd5, noWrite(), noExc(), 6'b101010, addrCause, 0);
        addStep(3'd5, noWrite(), noExc(), 6'b010101, addrCause, 0);
        addStep(3'd5, noWrite(), noExc(), 6'b111111, addrStatus, 0);
        addStep(3'd5, noWrite(), noExc(), 6'd0, addrCause, 0);
    endfunction

    function automatic string testName(input int id);
        case (id)
            0:       return "reset values";
            1:       return "round trips";
            2:       return "exception entry";
            3:       return "bad vaddr";
            4:       return "timer";
            default: return "hw interrupts";
        endcase
    endfunction

    function automatic void checkStep(input int i);
        if (rdData !== steps[i].expRd) begin
            $display("error rdData step %0d addr 0x%h: expected 0x%h, got 0x%h", i,
                steps[i].rdAddr, steps[i].expRd, rdData);
            testErrors++;
        end
        if (intrView !== steps[i].expIntr) begin
            $display("error intrView step %0d: expected 0x%h, got 0x%h", i,
                steps[i].expIntr, intrView);
            testErrors++;
        end
        if (epc !== steps[i].expEpc) begin
            $display("error epc step %0d: expected 0x%h, got 0x%h", i, steps[i].expEpc, epc);
            testErrors++;
        end
    endfunction

    function automatic void reportTest(input int id);
        if (testErrors == 0) begin
            $display("test %0d %s: passed", id, testName(id));
            passedTests++;
        end else begin
            $display("test %0d %s: FAILED with %0d errors", id, testName(id), testErrors);
            failedTests++;
        end
        totalErrors += testErrors;
        testErrors = 0;
    endfunction

    initial begin
        wait (cycleLimit != 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int tableCycles;
        rstN   <= 1'b0;
        wrReq  <= noWrite();
        exc    <= noExc();
        hwInt  <= 6'd0;
        rdAddr <= addrCount;
        buildTable();
        tableCycles = 0;
        foreach (steps[i]) tableCycles += 2 + int'(steps[i].idle);
        cycleLimit = 4 + tableCycles + 20;    // Reset plus slack
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        if (rdData !== 32'd0) begin
            $display("error rdData reset Count: expected 0x00000000, got 0x%h", rdData);
            testErrors++;
        end
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            wrReq  <= steps[i].wr;
            exc    <= steps[i].exc;
            hwInt  <= steps[i].hwInt;
            rdAddr <= steps[i].rdAddr;
            @(posedge clk);
            wrReq <= noWrite();
            exc   <= noExc();
            repeat (steps[i].idle) @(posedge clk);
            @(negedge clk);
            checkStep(i);
            if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
                reportTest(int'(steps[i].test));
            end
        end
        $display("totals: %0d tests, %0d passed, %0d failed, %0d errors, %0d assert failures",
            passedTests + failedTests, passedTests, failedTests, totalErrors,
            u_cp0Top.u_cp0TopProperties.failCount);
        if (totalErrors == 0 && u_cp0Top.u_cp0TopProperties.failCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/cp0Pkg.sv
source/cp0Timer.sv
source/cp0StatusRegs.sv
source/cp0ExcUnit.sv
source/cp0ReadPort.sv
source/cp0Top.sv
tb/cp0Top_properties.sv
tb/cp0Tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cp0Tb
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out=$$($(BIN) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
